/* logic/isa_pkg.sv */
package isa_pkg;

    // Primary opcode field in bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // Function field in bits 5:0 of R-type words
    typedef enum logic [5:0] {
        FUNCT_ADD = 6'h20,
        FUNCT_SUB = 6'h22,
        FUNCT_AND = 6'h24
    } funct_e;

    // One class per supported instruction
    typedef enum logic [3:0] {
        INSTR_ADD,
        INSTR_SUB,
        INSTR_AND,
        INSTR_ADDI,
        INSTR_LW,
        INSTR_SW,
        INSTR_BEQ,
        INSTR_BNE,
        INSTR_J,
        INSTR_ILLEGAL
    } instr_e;

endpackage

/* logic/ctrl_pkg.sv */
package ctrl_pkg;

    // Memory reads are held this many cycles before the data is used
    localparam int MEM_WAIT_CYCLES = 3;
    localparam int WAIT_COUNT_W    = 2;

    typedef enum logic [4:0] {
        // Shared fetch phase
        ST_FETCH_WAIT,
        ST_FETCH,
        ST_DECODE,
        ST_DISPATCH,
        // ALU operations and writeback
        ST_ALU_ADD,
        ST_ALU_SUB,
        ST_ALU_AND,
        ST_ALU_IMM,
        ST_ALU_WB,
        ST_IMM_WB,
        // Loads and stores
        ST_ADDR,
        ST_LOAD_WAIT,
        ST_LOAD_MDR,
        ST_LOAD_WB,
        ST_STORE,
        // Control flow
        ST_BRANCH,
        ST_JUMP,
        // Exception entry
        ST_EXC_WAIT,
        ST_EXCEPT
    } state_e;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND} alu_op_e;

    typedef enum logic {SRC_A_PC, SRC_A_REG} alu_src_a_e;

    typedef enum logic [1:0] {
        SRC_B_REG,
        SRC_B_FOUR,
        SRC_B_IMM,
        SRC_B_BRANCH_OFFSET
    } alu_src_b_e;

    typedef enum logic [1:0] {ADDR_PC, ADDR_ALU, ADDR_VECTOR} iord_e;

    typedef enum logic [1:0] {PC_ALU, PC_ALU_OUT, PC_JUMP, PC_VECTOR} pc_src_e;

    typedef enum logic {EXC_OPCODE, EXC_OVERFLOW} except_e;

    typedef enum logic {DST_RT, DST_RD} reg_dst_e;

    typedef enum logic {WB_ALU_OUT, WB_MDR} mem_to_reg_e;

endpackage

/* logic/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode
    import isa_pkg::*;
(
    input  opcode_e opcode,
    input  funct_e  funct,
    output instr_e  instr
);

    always_comb begin
        case (opcode)
            OP_RTYPE: begin
                // Only three R-type functions exist in this datapath
                case (funct)
                    FUNCT_ADD: begin
                        instr = INSTR_ADD;
                    end
                    FUNCT_SUB: begin
                        instr = INSTR_SUB;
                    end
                    FUNCT_AND: begin
                        instr = INSTR_AND;
                    end
                    default: begin
                        instr = INSTR_ILLEGAL;
                    end
                endcase
            end
            OP_ADDI: begin
                instr = INSTR_ADDI;
            end
            OP_LW: begin
                instr = INSTR_LW;
            end
            OP_SW: begin
                instr = INSTR_SW;
            end
            OP_BEQ: begin
                instr = INSTR_BEQ;
            end
            OP_BNE: begin
                instr = INSTR_BNE;
            end
            OP_J: begin
                instr = INSTR_J;
            end
            default: begin
                instr = INSTR_ILLEGAL;
            end
        endcase
    end

endmodule

/* logic/control_sequencer.sv */
`timescale 1ns/1ps

module control_sequencer
    import isa_pkg::*, ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  instr_e  instr,
    input  logic    eq,
    input  logic    overflow,
    output state_e  state,
    output except_e except_cause
);

    state_e                  next_state;
    logic [WAIT_COUNT_W-1:0] wait_count;
    logic                    in_wait;
    logic                    wait_done;
    logic                    enter_exc;
    except_e                 new_cause;

    assign in_wait   = (state == ST_FETCH_WAIT) || (state == ST_LOAD_WAIT) ||
                       (state == ST_EXC_WAIT);
    assign wait_done = (wait_count == WAIT_COUNT_W'(MEM_WAIT_CYCLES - 1));

    always_comb begin
        next_state = state;
        enter_exc  = 1'b0;
        new_cause  = EXC_OPCODE;
        case (state)
            ST_FETCH_WAIT: begin
                if (wait_done) begin
                    next_state = ST_FETCH;
                end
            end
            ST_FETCH: begin
                next_state = ST_DECODE;
            end
            ST_DECODE: begin
                next_state = ST_DISPATCH;
            end
            ST_DISPATCH: begin
                case (instr)
                    INSTR_ADD:  next_state = ST_ALU_ADD;
                    INSTR_SUB:  next_state = ST_ALU_SUB;
                    INSTR_AND:  next_state = ST_ALU_AND;
                    INSTR_ADDI: next_state = ST_ALU_IMM;
                    INSTR_LW:   next_state = ST_ADDR;
                    INSTR_SW:   next_state = ST_ADDR;
                    INSTR_BEQ:  next_state = eq ? ST_BRANCH : ST_FETCH_WAIT;
                    INSTR_BNE:  next_state = eq ? ST_FETCH_WAIT : ST_BRANCH;
                    INSTR_J:    next_state = ST_JUMP;
                    default: begin
                        next_state = ST_EXC_WAIT;
                        enter_exc  = 1'b1;
                        new_cause  = EXC_OPCODE;
                    end
                endcase
            end
            ST_ALU_ADD, ST_ALU_SUB, ST_ALU_AND, ST_ALU_IMM: begin
                if (overflow) begin
                    // Result is discarded without writeback
                    next_state = ST_EXC_WAIT;
                    enter_exc  = 1'b1;
                    new_cause  = EXC_OVERFLOW;
                end else if (state == ST_ALU_IMM) begin
                    next_state = ST_IMM_WB;
                end else begin
                    next_state = ST_ALU_WB;
                end
            end
            ST_ADDR: begin
                next_state = (instr == INSTR_SW) ? ST_STORE : ST_LOAD_WAIT;
            end
            ST_LOAD_WAIT: begin
                if (wait_done) begin
                    next_state = ST_LOAD_MDR;
                end
            end
            ST_LOAD_MDR: begin
                next_state = ST_LOAD_WB;
            end
            ST_EXC_WAIT: begin
                if (wait_done) begin
                    next_state = ST_EXCEPT;
                end
            end
            default: begin
                // Single-cycle terminal states return to fetch
                next_state = ST_FETCH_WAIT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= ST_FETCH_WAIT;
            wait_count   <= '0;
            except_cause <= EXC_OPCODE;
        end else begin
            state <= next_state;
            if (in_wait && !wait_done) begin
                wait_count <= wait_count + 1'b1;
            end else begin
                wait_count <= '0;
            end
            if (enter_exc) begin
                except_cause <= new_cause;
            end
        end
    end

endmodule

/* logic/control_encoder.sv */
`timescale 1ns/1ps

module control_encoder
    import ctrl_pkg::*;
(
    input  state_e      state,
    output logic        pc_write,
    output logic        ir_write,
    output logic        a_write,
    output logic        b_write,
    output logic        alu_out_write,
    output logic        mdr_write,
    output logic        mem_wr,
    output logic        reg_write,
    output logic        epc_write,
    output alu_op_e     alu_op,
    output alu_src_a_e  alu_src_a,
    output alu_src_b_e  alu_src_b,
    output iord_e       iord,
    output pc_src_e     pc_src,
    output reg_dst_e    reg_dst,
    output mem_to_reg_e mem_to_reg
);

    always_comb begin
        // Idle word computes PC plus four with every enable low
        pc_write      = 1'b0;
        ir_write      = 1'b0;
        a_write       = 1'b0;
        b_write       = 1'b0;
        alu_out_write = 1'b0;
        mdr_write     = 1'b0;
        mem_wr        = 1'b0;
        reg_write     = 1'b0;
        epc_write     = 1'b0;
        alu_op        = ALU_ADD;
        alu_src_a     = SRC_A_PC;
        alu_src_b     = SRC_B_FOUR;
        iord          = ADDR_PC;
        pc_src        = PC_ALU;
        reg_dst       = DST_RT;
        mem_to_reg    = WB_ALU_OUT;
        case (state)
            ST_FETCH: begin
                pc_write = 1'b1;
                ir_write = 1'b1;
            end
            ST_DECODE: begin
                a_write       = 1'b1;
                b_write       = 1'b1;
                alu_out_write = 1'b1;
                alu_src_b     = SRC_B_BRANCH_OFFSET;
            end
            ST_ALU_ADD, ST_ALU_SUB, ST_ALU_AND: begin
                alu_out_write = 1'b1;
                alu_src_a     = SRC_A_REG;
                alu_src_b     = SRC_B_REG;
                if (state == ST_ALU_SUB) begin
                    alu_op = ALU_SUB;
                end else if (state == ST_ALU_AND) begin
                    alu_op = ALU_AND;
                end
            end
            ST_ALU_IMM, ST_ADDR: begin
                alu_out_write = 1'b1;
                alu_src_a     = SRC_A_REG;
                alu_src_b     = SRC_B_IMM;
            end
            ST_ALU_WB: begin
                reg_write = 1'b1;
                reg_dst   = DST_RD;
            end
            ST_IMM_WB: begin
                reg_write = 1'b1;
            end
            ST_LOAD_WAIT: begin
                iord = ADDR_ALU;
            end
            ST_LOAD_MDR: begin
                mdr_write = 1'b1;
                iord      = ADDR_ALU;
            end
            ST_LOAD_WB: begin
                reg_write  = 1'b1;
                mem_to_reg = WB_MDR;
            end
            ST_STORE: begin
                mem_wr = 1'b1;
                iord   = ADDR_ALU;
            end
            ST_BRANCH: begin
                pc_write = 1'b1;
                pc_src   = PC_ALU_OUT;
            end
            ST_JUMP: begin
                pc_write = 1'b1;
                pc_src   = PC_JUMP;
            end
            ST_EXC_WAIT: begin
                // ALU backs PC up to the faulting instruction for EPC
                iord   = ADDR_VECTOR;
                alu_op = ALU_SUB;
            end
            ST_EXCEPT: begin
                epc_write = 1'b1;
                pc_write  = 1'b1;
                pc_src    = PC_VECTOR;
                alu_op    = ALU_SUB;
            end
            default: begin
            end
        endcase
    end

endmodule

/* logic/control_unit.sv */
`timescale 1ns/1ps

module control_unit
    import isa_pkg::*, ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  opcode_e     opcode,
    input  funct_e      funct,
    input  logic        eq,
    input  logic        overflow,
    output logic        pc_write,
    output logic        ir_write,
    output logic        a_write,
    output logic        b_write,
    output logic        alu_out_write,
    output logic        mdr_write,
    output logic        mem_wr,
    output logic        reg_write,
    output logic        epc_write,
    output alu_op_e     alu_op,
    output alu_src_a_e  alu_src_a,
    output alu_src_b_e  alu_src_b,
    output iord_e       iord,
    output pc_src_e     pc_src,
    output reg_dst_e    reg_dst,
    output mem_to_reg_e mem_to_reg,
    output except_e     except_cause
);

    instr_e instr;
    state_e state;

    instr_decode i_decode (
        .opcode (opcode),
        .funct  (funct),
        .instr  (instr)
    );

    control_sequencer i_sequencer (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .eq           (eq),
        .overflow     (overflow),
        .state        (state),
        .except_cause (except_cause)
    );

    control_encoder i_encoder (
        .state         (state),
        .pc_write      (pc_write),
        .ir_write      (ir_write),
        .a_write       (a_write),
        .b_write       (b_write),
        .alu_out_write (alu_out_write),
        .mdr_write     (mdr_write),
        .mem_wr        (mem_wr),
        .reg_write     (reg_write),
        .epc_write     (epc_write),
        .alu_op        (alu_op),
        .alu_src_a     (alu_src_a),
        .alu_src_b     (alu_src_b),
        .iord          (iord),
        .pc_src        (pc_src),
        .reg_dst       (reg_dst),
        .mem_to_reg    (mem_to_reg)
    );

endmodule

/* test/control_model.svh */
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

// Reference sequence state and the control word it implies
state_e      m_state;
int          m_left;
except_e     m_cause;
logic [8:0]  exp_en;
alu_op_e     exp_alu_op;
alu_src_a_e  exp_src_a;
alu_src_b_e  exp_src_b;
iord_e       exp_iord;
pc_src_e     exp_pc_src;
reg_dst_e    exp_dst;
mem_to_reg_e exp_wb;

task automatic start_wait(state_e s);
    m_state = s;
    m_left  = MEM_WAIT_CYCLES;
endtask

task automatic reset_model();
    start_wait(ST_FETCH_WAIT);
    m_cause = EXC_OPCODE;
endtask

task automatic step_model(instr_e cls, logic eq_v, logic ovf_v);
    case (m_state)
        ST_FETCH_WAIT, ST_LOAD_WAIT, ST_EXC_WAIT: begin
            if (m_left > 1) begin
                m_left = m_left - 1;
            end else if (m_state == ST_FETCH_WAIT) begin
                m_state = ST_FETCH;
            end else if (m_state == ST_LOAD_WAIT) begin
                m_state = ST_LOAD_MDR;
            end else begin
                m_state = ST_EXCEPT;
            end
        end
        ST_FETCH:    m_state = ST_DECODE;
        ST_DECODE:   m_state = ST_DISPATCH;
        ST_DISPATCH: begin
            case (cls)
                INSTR_ADD:          m_state = ST_ALU_ADD;
                INSTR_SUB:          m_state = ST_ALU_SUB;
                INSTR_AND:          m_state = ST_ALU_AND;
                INSTR_ADDI:         m_state = ST_ALU_IMM;
                INSTR_LW, INSTR_SW: m_state = ST_ADDR;
                INSTR_J:            m_state = ST_JUMP;
                INSTR_BEQ, INSTR_BNE: begin
                    // Taken when eq matches the branch sense
                    if (eq_v == (cls == INSTR_BEQ)) begin
                        m_state = ST_BRANCH;
                    end else begin
                        start_wait(ST_FETCH_WAIT);
                    end
                end
                default: begin
                    m_cause = EXC_OPCODE;
                    start_wait(ST_EXC_WAIT);
                end
            endcase
        end
        ST_ALU_ADD, ST_ALU_SUB, ST_ALU_AND, ST_ALU_IMM: begin
            if (ovf_v) begin
                m_cause = EXC_OVERFLOW;
                start_wait(ST_EXC_WAIT);
            end else if (m_state == ST_ALU_IMM) begin
                m_state = ST_IMM_WB;
            end else begin
                m_state = ST_ALU_WB;
            end
        end
        ST_ADDR: begin
            if (cls == INSTR_SW) begin
                m_state = ST_STORE;
            end else begin
                start_wait(ST_LOAD_WAIT);
            end
        end
        ST_LOAD_MDR: m_state = ST_LOAD_WB;
        default:     start_wait(ST_FETCH_WAIT);
    endcase
endtask

// Enable bits from the top are pc, ir, a, b, alu_out, mdr, mem_wr, reg and epc
task automatic expected_word();
    exp_en     = 9'b0;
    exp_alu_op = ALU_ADD;
    exp_src_a  = SRC_A_PC;
    exp_src_b  = SRC_B_FOUR;
    exp_iord   = ADDR_PC;
    exp_pc_src = PC_ALU;
    exp_dst    = DST_RT;
    exp_wb     = WB_ALU_OUT;
    case (m_state)
        ST_FETCH: exp_en = 9'b110000000;
        ST_DECODE: begin
            exp_en    = 9'b001110000;
            exp_src_b = SRC_B_BRANCH_OFFSET;
        end
        ST_ALU_ADD, ST_ALU_SUB, ST_ALU_AND: begin
            exp_en    = 9'b000010000;
            exp_src_a = SRC_A_REG;
            exp_src_b = SRC_B_REG;
            if (m_state == ST_ALU_SUB) begin
                exp_alu_op = ALU_SUB;
            end else if (m_state == ST_ALU_AND) begin
                exp_alu_op = ALU_AND;
            end
        end
        ST_ALU_IMM, ST_ADDR: begin
            exp_en    = 9'b000010000;
            exp_src_a = SRC_A_REG;
            exp_src_b = SRC_B_IMM;
        end
        ST_ALU_WB: begin
            exp_en  = 9'b000000010;
            exp_dst = DST_RD;
        end
        ST_IMM_WB:    exp_en = 9'b000000010;
        ST_LOAD_WAIT: exp_iord = ADDR_ALU;
        ST_LOAD_MDR: begin
            exp_en   = 9'b000001000;
            exp_iord = ADDR_ALU;
        end
        ST_LOAD_WB: begin
            exp_en = 9'b000000010;
            exp_wb = WB_MDR;
        end
        ST_STORE: begin
            exp_en   = 9'b000000100;
            exp_iord = ADDR_ALU;
        end
        ST_BRANCH: begin
            exp_en     = 9'b100000000;
            exp_pc_src = PC_ALU_OUT;
        end
        ST_JUMP: begin
            exp_en     = 9'b100000000;
            exp_pc_src = PC_JUMP;
        end
        ST_EXC_WAIT: begin
            exp_iord   = ADDR_VECTOR;
            exp_alu_op = ALU_SUB;
        end
        ST_EXCEPT: begin
            exp_en     = 9'b100000001;
            exp_pc_src = PC_VECTOR;
            exp_alu_op = ALU_SUB;
        end
        default: begin
        end
    endcase
endtask

`endif

/* test/control_unit_tb.sv */
`timescale 1ns/1ps

module control_unit_tb
    import isa_pkg::*, ctrl_pkg::*;
();

    localparam int NUM_INSTR     = 300;
    localparam int FETCH_TIMEOUT = 20;

    logic        clk;
    logic        reset;
    opcode_e     opcode;
    funct_e      funct;
    logic        eq;
    logic        overflow;
    logic        pc_write;
    logic        ir_write;
    logic        a_write;
    logic        b_write;
    logic        alu_out_write;
    logic        mdr_write;
    logic        mem_wr;
    logic        reg_write;
    logic        epc_write;
    alu_op_e     alu_op;
    alu_src_a_e  alu_src_a;
    alu_src_b_e  alu_src_b;
    iord_e       iord;
    pc_src_e     pc_src;
    reg_dst_e    reg_dst;
    mem_to_reg_e mem_to_reg;
    except_e     except_cause;

    logic [31:0] seed = 32'hf916;
    int          errors = 0;
    int          checks = 0;
    bit          started = 1'b0;
    int          fetch_cycles;
    bit          fetch_timed_out;
    instr_e      cur_cls;
    logic [5:0]  next_op;
    logic [5:0]  next_fn;
    instr_e      next_cls;
    logic        next_eq;
    logic        next_ovf;

    `include "control_model.svh"

    control_unit i_dut (
        .clk           (clk),
        .reset         (reset),
        .opcode        (opcode),
        .funct         (funct),
        .eq            (eq),
        .overflow      (overflow),
        .pc_write      (pc_write),
        .ir_write      (ir_write),
        .a_write       (a_write),
        .b_write       (b_write),
        .alu_out_write (alu_out_write),
        .mdr_write     (mdr_write),
        .mem_wr        (mem_wr),
        .reg_write     (reg_write),
        .epc_write     (epc_write),
        .alu_op        (alu_op),
        .alu_src_a     (alu_src_a),
        .alu_src_b     (alu_src_b),
        .iord          (iord),
        .pc_src        (pc_src),
        .reg_dst       (reg_dst),
        .mem_to_reg    (mem_to_reg),
        .except_cause  (except_cause)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic bit is_known_opcode(logic [5:0] v);
        return v inside {OP_RTYPE, OP_J, OP_BEQ, OP_BNE, OP_ADDI, OP_LW, OP_SW};
    endfunction

    function automatic bit is_known_funct(logic [5:0] v);
        return v inside {FUNCT_ADD, FUNCT_SUB, FUNCT_AND};
    endfunction

    task automatic check_value(string name, int exp_v, int act_v);
        checks++;
        assert (act_v == exp_v) else begin
            errors++;
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp_v, act_v);
        end
    endtask

    task automatic check_outputs();
        expected_word();
        check_value("pc_write", int'(exp_en[8]), int'(pc_write));
        check_value("ir_write", int'(exp_en[7]), int'(ir_write));
        check_value("a_write", int'(exp_en[6]), int'(a_write));
        check_value("b_write", int'(exp_en[5]), int'(b_write));
        check_value("alu_out_write", int'(exp_en[4]), int'(alu_out_write));
        check_value("mdr_write", int'(exp_en[3]), int'(mdr_write));
        check_value("mem_wr", int'(exp_en[2]), int'(mem_wr));
        check_value("reg_write", int'(exp_en[1]), int'(reg_write));
        check_value("epc_write", int'(exp_en[0]), int'(epc_write));
        check_value("alu_op", int'(exp_alu_op), int'(alu_op));
        check_value("alu_src_a", int'(exp_src_a), int'(alu_src_a));
        check_value("alu_src_b", int'(exp_src_b), int'(alu_src_b));
        check_value("iord", int'(exp_iord), int'(iord));
        check_value("pc_src", int'(exp_pc_src), int'(pc_src));
        check_value("reg_dst", int'(exp_dst), int'(reg_dst));
        check_value("mem_to_reg", int'(exp_wb), int'(mem_to_reg));
        check_value("except_cause", int'(m_cause), int'(except_cause));
    endtask

    // Outputs are compared mid-cycle before the model advances
    always @(negedge clk) begin
        if (started) begin
            if (reset) begin
                reset_model();
            end
            check_outputs();
            if (!reset) begin
                step_model(cur_cls, eq, overflow);
            end
        end
    end

    task automatic wait_for_fetch();
        fetch_cycles    = 0;
        fetch_timed_out = 1'b0;
        do begin
            @(negedge clk);
            fetch_cycles = fetch_cycles + 1;
        end while (ir_write !== 1'b1 && fetch_cycles < FETCH_TIMEOUT);
        assert (ir_write === 1'b1) else begin
            errors++;
            fetch_timed_out = 1'b1;
            $display("No instruction fetch occurred within %0d cycles", FETCH_TIMEOUT);
        end
    endtask

    task automatic pick_instruction();
        logic [31:0] r;
        int          sel;
        r        = next_rand();
        sel      = int'((r >> 16) % 32'd11);
        next_fn  = r[13:8];
        next_eq  = r[20];
        next_ovf = (r[23:22] == 2'b00);
        case (sel)
            0, 1, 2: begin
                next_op  = OP_RTYPE;
                next_fn  = (sel == 0) ? FUNCT_ADD : (sel == 1) ? FUNCT_SUB : FUNCT_AND;
                next_cls = (sel == 0) ? INSTR_ADD : (sel == 1) ? INSTR_SUB : INSTR_AND;
            end
            3: begin
                next_op  = OP_ADDI;
                next_cls = INSTR_ADDI;
            end
            4: begin
                next_op  = OP_LW;
                next_cls = INSTR_LW;
            end
            5: begin
                next_op  = OP_SW;
                next_cls = INSTR_SW;
            end
            6: begin
                next_op  = OP_BEQ;
                next_cls = INSTR_BEQ;
            end
            7: begin
                next_op  = OP_BNE;
                next_cls = INSTR_BNE;
            end
            8: begin
                next_op  = OP_J;
                next_cls = INSTR_J;
            end
            9: begin
                // Inverting a defined opcode always lands on an undefined one
                next_op  = is_known_opcode(r[5:0]) ? ~r[5:0] : r[5:0];
                next_cls = INSTR_ILLEGAL;
            end
            default: begin
                next_op  = OP_RTYPE;
                next_fn  = is_known_funct(r[13:8]) ? ~r[13:8] : r[13:8];
                next_cls = INSTR_ILLEGAL;
            end
        endcase
    endtask

    initial begin
        reset    = 1'b1;
        opcode   = OP_RTYPE;
        funct    = FUNCT_ADD;
        eq       = 1'b0;
        overflow = 1'b0;
        cur_cls  = INSTR_ADD;
        @(posedge clk);
        started = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        wait_for_fetch();
        assert (fetch_timed_out || fetch_cycles == MEM_WAIT_CYCLES + 1) else begin
            errors++;
            $display("First fetch came %0d cycles after reset instead of %0d",
                     fetch_cycles, MEM_WAIT_CYCLES + 1);
        end

        for (int n = 0; n < NUM_INSTR && !fetch_timed_out; n++) begin
            pick_instruction();
            @(posedge clk);
            opcode   <= opcode_e'(next_op);
            funct    <= funct_e'(next_fn);
            eq       <= next_eq;
            overflow <= next_ovf;
            cur_cls  <= next_cls;
            wait_for_fetch();
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* control_unit.f */
+incdir+test
logic/isa_pkg.sv
logic/ctrl_pkg.sv
logic/instr_decode.sv
logic/control_sequencer.sv
logic/control_encoder.sv
logic/control_unit.sv
test/control_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert --top-module control_unit_tb -f control_unit.f -o control_unit_sim
./obj_dir/control_unit_sim | tee sim.log

if grep -qx "No errors" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
